/* common/amp_macros.svh */
`ifndef AMP_MACROS_SVH
`define AMP_MACROS_SVH

// Datapath widths
`define AMP_SAMPLE_W      32
`define AMP_LOOP_W        24
`define AMP_GAIN_W        7
`define AMP_GAIN_MAX      127

// Effect levels and thresholds
`define AMP_DRIVE         700000000
`define AMP_AMPLITUDE     500000000
`define AMP_FUZZ_THRESH   10000
`define AMP_SQUARE_THRESH 9000000

// Loop memory
`define AMP_LOOP_DEPTH    64
`define AMP_LOOP_ADDR_W   6
`define AMP_MIX_SHIFT     7   // 2^8 restore, then half weight

// Tremolo LFO
`define AMP_LFO_STEPS     360
`define AMP_LFO_RATE      15  // Samples per phase step
`define AMP_LFO_PHASE_W   9
`define AMP_LFO_LEVEL_W   3

`endif

/* common/amp_pkg.sv */
`include "amp_macros.svh"

package amp_pkg;

	// Audio samples, full and reduced
	typedef logic signed [`AMP_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`AMP_LOOP_W-1:0]   loop_sample_t;

	typedef logic [`AMP_GAIN_W-1:0] gain_t;

	typedef logic [`AMP_LOOP_ADDR_W-1:0] loop_addr_t;

	// Tremolo lookup
	typedef logic [`AMP_LFO_PHASE_W-1:0] lfo_phase_t;
	typedef logic [`AMP_LFO_LEVEL_W-1:0] lfo_level_t;   // Divisor 1..5

	typedef enum logic [1:0] {
		REC_IDLE,
		REC_RECORD,
		REC_PLAY
	} rec_state_t;

endpackage

/* effects/effects_path.sv */
`include "amp_macros.svh"

module effects_path (
	input  logic             clk,
	input  logic             reset,
	input  amp_pkg::sample_t in_sample,
	input  logic             in_valid,
	input  amp_pkg::gain_t   gain,
	input  logic             overdrive,
	input  logic             tremolo,
	input  logic             fuzz,
	input  logic             square,
	output amp_pkg::sample_t shaped,
	output logic             shaped_valid
);

	amp_pkg::gain_t      eff_gain;
	amp_pkg::sample_t    divisor;
	amp_pkg::sample_t    pregain;
	amp_pkg::sample_t    effect_out;
	amp_pkg::lfo_level_t lfo_level;
	logic                lfo_step;

	assign lfo_step = in_valid;   // One LFO tick per sample

	tremolo_lfo u_lfo (
		.clk   (clk),
		.reset (reset),
		.step  (lfo_step),
		.level (lfo_level)
	);

	// Pregain, divisor kept in 1..127
	always_comb begin
		if (gain > amp_pkg::gain_t'(`AMP_GAIN_MAX - 1))
			eff_gain = amp_pkg::gain_t'(`AMP_GAIN_MAX - 1);
		else
			eff_gain = gain;
		divisor = amp_pkg::sample_t'(amp_pkg::gain_t'(`AMP_GAIN_MAX) - eff_gain);
		pregain = in_sample / divisor;
	end

	// Highest priority effect wins
	always_comb begin
		if (square) begin
			if (pregain > `AMP_SQUARE_THRESH)
				effect_out = `AMP_AMPLITUDE;
			else if (pregain < -`AMP_SQUARE_THRESH)
				effect_out = -`AMP_AMPLITUDE;
			else
				effect_out = pregain;   // Small signals pass
		end else if (fuzz) begin
			if (pregain > `AMP_FUZZ_THRESH)
				effect_out = `AMP_AMPLITUDE;
			else if (pregain < -`AMP_FUZZ_THRESH)
				effect_out = -`AMP_AMPLITUDE;
			else
				effect_out = '0;
		end else if (tremolo) begin
			effect_out = pregain / amp_pkg::sample_t'(lfo_level);
		end else if (overdrive) begin
			if (pregain > `AMP_DRIVE)
				effect_out = `AMP_DRIVE;
			else if (pregain < -`AMP_DRIVE)
				effect_out = -`AMP_DRIVE;
			else
				effect_out = pregain;
		end else begin
			effect_out = pregain;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			shaped_valid <= 1'b0;
		else
			shaped_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			shaped <= effect_out;
	end

endmodule

/* effects/tremolo_lfo.sv */
`include "amp_macros.svh"

module tremolo_lfo (
	input  logic                clk,
	input  logic                reset,
	input  logic                step,
	output amp_pkg::lfo_level_t level
);

	amp_pkg::lfo_phase_t phase;
	logic [$clog2(`AMP_LFO_RATE)-1:0] rate_cnt;

	// Phase advances once every AMP_LFO_RATE samples
	always_ff @(posedge clk) begin
		if (reset) begin
			phase    <= '0;
			rate_cnt <= '0;
		end else if (step) begin
			if (rate_cnt == `AMP_LFO_RATE - 1) begin
				rate_cnt <= '0;
				if (phase == amp_pkg::lfo_phase_t'(`AMP_LFO_STEPS - 1))
					phase <= '0;
				else
					phase <= phase + 1'b1;
			end else begin
				rate_cnt <= rate_cnt + 1'b1;
			end
		end
	end

	// Coarse sine, shifted so the minimum divisor is 1
	always_comb begin
		case (phase) inside
			[9'd0:9'd14]:    level = 3'd3;
			[9'd15:9'd48]:   level = 3'd4;
			[9'd49:9'd131]:  level = 3'd5;   // Peak
			[9'd132:9'd165]: level = 3'd4;
			[9'd166:9'd194]: level = 3'd3;
			[9'd195:9'd228]: level = 3'd2;
			[9'd229:9'd311]: level = 3'd1;   // Trough, full volume
			[9'd312:9'd345]: level = 3'd2;
			default:         level = 3'd3;
		endcase
	end

endmodule

/* logic/guitar_amp.sv */
module guitar_amp (
	input  logic             clk,
	input  logic             reset,
	input  amp_pkg::sample_t in_sample,
	input  logic             in_valid,
	input  amp_pkg::gain_t   gain,
	input  logic             overdrive,
	input  logic             tremolo,
	input  logic             fuzz,
	input  logic             square,
	input  logic             record,
	input  logic             play,
	output amp_pkg::sample_t out_sample,
	output logic             out_valid
);

	amp_pkg::sample_t      shaped;
	logic                  shaped_valid;
	amp_pkg::loop_addr_t   mem_addr;
	amp_pkg::loop_sample_t mem_wdata;
	amp_pkg::loop_sample_t mem_rdata;
	logic                  mem_wen;

	effects_path u_effects (
		.clk          (clk),
		.reset        (reset),
		.in_sample    (in_sample),
		.in_valid     (in_valid),
		.gain         (gain),
		.overdrive    (overdrive),
		.tremolo      (tremolo),
		.fuzz         (fuzz),
		.square       (square),
		.shaped       (shaped),
		.shaped_valid (shaped_valid)
	);

	sound_memory u_mem (
		.clk   (clk),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.wen   (mem_wen),
		.rdata (mem_rdata)
	);

	loop_recorder u_recorder (
		.clk          (clk),
		.reset        (reset),
		.shaped       (shaped),
		.shaped_valid (shaped_valid),
		.record       (record),
		.play         (play),
		.mem_rdata    (mem_rdata),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_wen      (mem_wen),
		.out_sample   (out_sample),
		.out_valid    (out_valid)
	);

endmodule

/* playback/loop_recorder.sv */
`include "amp_macros.svh"

module loop_recorder (
	input  logic                  clk,
	input  logic                  reset,
	input  amp_pkg::sample_t      shaped,
	input  logic                  shaped_valid,
	input  logic                  record,
	input  logic                  play,
	input  amp_pkg::loop_sample_t mem_rdata,
	output amp_pkg::loop_addr_t   mem_addr,
	output amp_pkg::loop_sample_t mem_wdata,
	output logic                  mem_wen,
	output amp_pkg::sample_t      out_sample,
	output logic                  out_valid
);

	amp_pkg::rec_state_t state;
	amp_pkg::rec_state_t state_nxt;
	logic [`AMP_LOOP_ADDR_W:0] rec_len;    // 0..depth
	logic [`AMP_LOOP_ADDR_W:0] addr_inc;
	amp_pkg::sample_t wet;

	// Record beats play
	always_comb begin
		if (record)
			state_nxt = amp_pkg::REC_RECORD;
		else if (play)
			state_nxt = amp_pkg::REC_PLAY;
		else
			state_nxt = amp_pkg::REC_IDLE;
	end

	assign addr_inc  = {1'b0, mem_addr} + 1'b1;
	assign mem_wen   = shaped_valid && (state == amp_pkg::REC_RECORD);
	assign mem_wdata = shaped[`AMP_SAMPLE_W-1 -: `AMP_LOOP_W];   // Upper bits only
	assign wet       = shaped + (amp_pkg::sample_t'(mem_rdata) <<< `AMP_MIX_SHIFT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= amp_pkg::REC_IDLE;
			mem_addr <= '0;
			rec_len  <= '0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state) begin
				// Every mode starts at the loop head
				mem_addr <= '0;
				if (state_nxt == amp_pkg::REC_RECORD)
					rec_len <= '0;
			end else if (shaped_valid) begin
				case (state)
					amp_pkg::REC_RECORD: begin
						// Length saturates at depth once the buffer wraps
						if (addr_inc > rec_len)
							rec_len <= addr_inc;
						mem_addr <= addr_inc[`AMP_LOOP_ADDR_W-1:0];   // Wraps at depth
					end
					amp_pkg::REC_PLAY: begin
						if (addr_inc >= rec_len)
							mem_addr <= '0;
						else
							mem_addr <= addr_inc[`AMP_LOOP_ADDR_W-1:0];
					end
					default: mem_addr <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= shaped_valid;
	end

	// Mix only when something was recorded
	always_ff @(posedge clk) begin
		if (shaped_valid) begin
			if (state == amp_pkg::REC_PLAY && rec_len != '0)
				out_sample <= wet;
			else
				out_sample <= shaped;
		end
	end

endmodule

/* playback/sound_memory.sv */
`include "amp_macros.svh"

module sound_memory (
	input  logic                  clk,
	input  amp_pkg::loop_addr_t   addr,
	input  amp_pkg::loop_sample_t wdata,
	input  logic                  wen,
	output amp_pkg::loop_sample_t rdata
);

	amp_pkg::loop_sample_t mem [`AMP_LOOP_DEPTH];

	// Single port, old data on a write cycle
	always_ff @(posedge clk) begin
		if (wen)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the guitar amp testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_guitar_amp -f tb.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_guitar_amp +verilator+error+limit+10 > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "sim passed" sim.log && echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }

/* tb.f */
+incdir+common
common/amp_pkg.sv
effects/tremolo_lfo.sv
effects/effects_path.sv
playback/sound_memory.sv
playback/loop_recorder.sv
logic/guitar_amp.sv
test/guitar_amp_chk.sv
test/tb_guitar_amp.sv

/* test/guitar_amp_chk.sv */
`include "amp_macros.svh"

module guitar_amp_chk (
	input logic             clk,
	input logic             reset,
	input amp_pkg::sample_t in_sample,
	input logic             in_valid,
	input amp_pkg::gain_t   gain,
	input logic             overdrive,
	input logic             tremolo,
	input logic             fuzz,
	input logic             square,
	input logic             record,
	input logic             play,
	input amp_pkg::sample_t out_sample,
	input logic             out_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	amp_pkg::loop_sample_t shadow [`AMP_LOOP_DEPTH];   // Recorded loop, reduced
	amp_pkg::rec_state_t   last_mode;
	int wr_idx;
	int rd_idx;
	int rec_n;
	int exp_val;
	int exp_pre;
	logic exp_trem;

	logic lat_fail;
	logic extra_fail;
	logic rst_fail;
	logic val_fail;
	logic trem_fail;
	logic failed;

	initial begin
		lat_fail   = 1'b0;
		extra_fail = 1'b0;
		rst_fail   = 1'b0;
		val_fail   = 1'b0;
		trem_fail  = 1'b0;
	end

	assign failed = lat_fail | extra_fail | rst_fail | val_fail | trem_fail;

	function automatic int pregain_of(amp_pkg::sample_t s, amp_pkg::gain_t g);
		int div;
		if (g == 7'd127)
			div = 1;   // 127 behaves as 126
		else
			div = `AMP_GAIN_MAX - int'(g);
		return int'(s) / div;
	endfunction

	// Square, then fuzz, then overdrive; tremolo is checked apart
	function automatic int shape_of(int p, logic sq, logic fz, logic ov);
		if (sq) begin
			if (p > `AMP_SQUARE_THRESH)
				return `AMP_AMPLITUDE;
			if (p < -`AMP_SQUARE_THRESH)
				return -`AMP_AMPLITUDE;
			return p;
		end
		if (fz) begin
			if (p > `AMP_FUZZ_THRESH)
				return `AMP_AMPLITUDE;
			if (p < -`AMP_FUZZ_THRESH)
				return -`AMP_AMPLITUDE;
			return 0;
		end
		if (ov) begin
			if (p > `AMP_DRIVE)
				return `AMP_DRIVE;
			if (p < -`AMP_DRIVE)
				return -`AMP_DRIVE;
		end
		return p;
	endfunction

	function automatic logic trem_ok(int o, int p);
		int k;
		for (k = 1; k <= 5; k++) begin
			if (o == p / k)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Expected output per sample, with a shadow of the loop memory
	always_ff @(posedge clk) begin
		amp_pkg::rec_state_t mode;
		int pre;
		int dry;
		int wr;
		int rd;
		int n;
		mode = record ? amp_pkg::REC_RECORD : (play ? amp_pkg::REC_PLAY : amp_pkg::REC_IDLE);
		wr = wr_idx;
		rd = rd_idx;
		n = rec_n;
		if (reset) begin
			last_mode <= amp_pkg::REC_IDLE;
			wr_idx    <= 0;
			rd_idx    <= 0;
			rec_n     <= 0;
			exp_trem  <= 1'b0;
		end else begin
			if (mode != last_mode) begin
				wr = 0;   // New mode starts at the loop head
				rd = 0;
				if (mode == amp_pkg::REC_RECORD)
					n = 0;
			end
			if (in_valid) begin
				pre = pregain_of(in_sample, gain);
				dry = shape_of(pre, square, fuzz, overdrive);
				exp_pre  <= pre;
				exp_trem <= tremolo && !square && !fuzz;
				exp_val  <= dry;
				if (mode == amp_pkg::REC_RECORD) begin
					shadow[wr] <= amp_pkg::loop_sample_t'(dry >>> 8);
					if (wr + 1 > n)
						n = wr + 1;
					wr = (wr + 1) % `AMP_LOOP_DEPTH;
				end else if (mode == amp_pkg::REC_PLAY && n != 0) begin
					exp_val <= dry + (int'(shadow[rd]) <<< 7);   // Restore 2^8, half weight
					rd = (rd + 1 >= n) ? 0 : rd + 1;
				end
			end
			wr_idx    <= wr;
			rd_idx    <= rd;
			rec_n     <= n;
			last_mode <= mode;
		end
	end

	a_latency: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> ##2 out_valid)
		else begin
			lat_fail = 1'b1;
			$error("out_valid did not follow in_valid after 2 cycles at %0t", $time);
		end

	a_no_extra: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(in_valid, 2))
		else begin
			extra_fail = 1'b1;
			$error("out_valid rose without a matching in_valid at %0t", $time);
		end

	a_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else begin
			rst_fail = 1'b1;
			$error("out_valid high right after reset at %0t", $time);
		end

	a_value: assert property (@(posedge clk) disable iff (reset)
		out_valid && !exp_trem |-> out_sample == exp_val)
		else begin
			val_fail = 1'b1;
			$error("ERR %0t: out_sample %0d, expected %0d", $time, out_sample, exp_val);
		end

	a_tremolo: assert property (@(posedge clk) disable iff (reset)
		out_valid && exp_trem |-> trem_ok(out_sample, exp_pre))
		else begin
			trem_fail = 1'b1;
			$error("ERR %0t: out_sample %0d is not %0d over 1 to 5", $time, out_sample, exp_pre);
		end

endmodule

bind guitar_amp guitar_amp_chk u_chk (
	.clk        (clk),
	.reset      (reset),
	.in_sample  (in_sample),
	.in_valid   (in_valid),
	.gain       (gain),
	.overdrive  (overdrive),
	.tremolo    (tremolo),
	.fuzz       (fuzz),
	.square     (square),
	.record     (record),
	.play       (play),
	.out_sample (out_sample),
	.out_valid  (out_valid)
);

/* test/tb_guitar_amp.sv */
module tb_guitar_amp;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_SAMPLES = 200;
	localparam int WATCHDOG_NS = NUM_SAMPLES * 8 * 4 + 2000;

	logic             clk;
	logic             reset;
	amp_pkg::sample_t in_sample;
	logic             in_valid;
	amp_pkg::gain_t   gain;
	logic             overdrive;
	logic             tremolo;
	logic             fuzz;
	logic             square;
	logic             record;
	logic             play;
	amp_pkg::sample_t out_sample;
	logic             out_valid;

	guitar_amp UUT (
		.clk        (clk),
		.reset      (reset),
		.in_sample  (in_sample),
		.in_valid   (in_valid),
		.gain       (gain),
		.overdrive  (overdrive),
		.tremolo    (tremolo),
		.fuzz       (fuzz),
		.square     (square),
		.record     (record),
		.play       (play),
		.out_sample (out_sample),
		.out_valid  (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Mix of full-scale and small samples
	function automatic amp_pkg::sample_t rand_sample();
		int shift;
		shift = ($urandom % 4 == 0) ? 0 : int'($urandom % 24);
		return amp_pkg::sample_t'($urandom) >>> shift;
	endfunction

	function automatic amp_pkg::gain_t rand_gain();
		int g;
		g = int'($urandom % 160);
		if (g > 127)
			g = 127;   // Top setting shows up often
		return amp_pkg::gain_t'(g);
	endfunction

	// Called on a rising edge, returns on one
	task automatic send_sample(input amp_pkg::sample_t s, input amp_pkg::gain_t g);
		int idle;
		idle = 3 + int'($urandom % 4);
		in_sample <= s;
		gain      <= g;
		in_valid  <= 1'b1;
		@(posedge clk);
		in_valid <= 1'b0;
		repeat (idle) @(posedge clk);
	endtask

	task automatic set_mode(input logic od, input logic tr, input logic fz, input logic sq,
		input logic rec, input logic pl);
		overdrive <= od;
		tremolo   <= tr;
		fuzz      <= fz;
		square    <= sq;
		record    <= rec;
		play      <= pl;
		repeat (4) @(posedge clk);
	endtask

	task automatic run_phase(input int count);
		repeat (count) send_sample(rand_sample(), rand_gain());
	endtask

	always @(posedge clk) begin
		if (UUT.u_chk.failed) begin
			$display("sim failed");
			$fatal(1, "a checker assertion failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("sim failed");
		$fatal(1, "watchdog expired before the stimulus finished");
	end

	initial begin
		void'($urandom(98077));
		reset     = 1'b1;
		in_sample = '0;
		in_valid  = 1'b0;
		gain      = '0;
		overdrive = 1'b0;
		tremolo   = 1'b0;
		fuzz      = 1'b0;
		square    = 1'b0;
		record    = 1'b0;
		play      = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (5) @(posedge clk);

		run_phase(30);                                   // Bypass
		set_mode(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		send_sample(32'sh7fff_fff0, 7'd127);             // Past both clip levels
		send_sample(-32'sh7fff_fff0, 7'd127);
		run_phase(20);
		set_mode(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		run_phase(20);
		set_mode(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);    // Square over fuzz
		run_phase(20);
		set_mode(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		run_phase(30);

		// Record a short loop, then play it past two wraps
		set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		run_phase(16);
		set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		run_phase(40);
		set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		repeat (10) @(posedge clk);

		if (UUT.u_chk.failed) begin
			$display("sim failed");
			$fatal(1, "a checker assertion failed");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule
